/* hw/acq_pkg.sv */
`default_nettype none

package acq_pkg;

  ////////////////////////////////////////////////////////////
  // widths

  localparam int REG_W         = 32;
  localparam int ADDR_W        = 8;
  localparam int FRAME_W       = ADDR_W + REG_W;         // address byte then data word
  localparam int BIT_CNT_W     = $clog2(FRAME_W + 1);    // saturating frame bit count
  localparam int REG_WRITE_BIT = 7;                      // set for write, clear for read
  localparam int COUNT_W       = 24;                     // precharge and aperture timers
  localparam int SEQ_ENTRY_W   = 6;                      // azmux 3:0, pc_sw 5:4
  localparam int SEQ_IDX_W     = 3;
  localparam int OUT_W         = 26;                     // pin bundle, leds at bit 0

  ////////////////////////////////////////////////////////////
  // register map

  localparam logic [ADDR_W-1:0] REG_ADDR_CR        = 8'd1;   // mode in 2:0
  localparam logic [ADDR_W-1:0] REG_ADDR_DIRECT    = 8'd2;
  localparam logic [ADDR_W-1:0] REG_ADDR_4094_OE   = 8'd3;
  localparam logic [ADDR_W-1:0] REG_ADDR_PRECHARGE = 8'd4;
  localparam logic [ADDR_W-1:0] REG_ADDR_SEQ_N     = 8'd5;
  localparam logic [ADDR_W-1:0] REG_ADDR_SEQ0      = 8'd6;
  localparam logic [ADDR_W-1:0] REG_ADDR_SEQ1      = 8'd7;
  localparam logic [ADDR_W-1:0] REG_ADDR_SEQ2      = 8'd8;
  localparam logic [ADDR_W-1:0] REG_ADDR_SEQ3      = 8'd9;
  localparam logic [ADDR_W-1:0] REG_ADDR_APERTURE  = 8'd10;
  localparam logic [ADDR_W-1:0] REG_ADDR_STATUS    = 8'd11;  // read only

  localparam logic [7:0] STATUS_MAGIC = 8'hAA;

  // chip-select vector, one code per spi device
  typedef enum logic [2:0] {
    CS_DEASSERT   = 3'd0,
    CS_FPGA0      = 3'd1,
    CS_4094       = 3'd2,
    CS_INVERT_DAC = 3'd3,
    CS_MDAC1      = 3'd4
  } spi_cs_e;

  typedef enum logic [2:0] {
    MODE_DIRECT   = 3'd0,   // register drives every pin
    MODE_SEQ_MOCK = 3'd6    // sequencer with mocked adc
  } mode_e;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRECHARGE,
    ST_MEASURE
  } seq_state_e;

endpackage

`default_nettype wire

/* hw/seq_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

// static sequencer setup, levels only
interface seq_cfg_if;
  import acq_pkg::*;

  logic [SEQ_IDX_W-1:0]   seq_n;       // sequence length, 0 acts as 1
  logic [SEQ_ENTRY_W-1:0] seq0;
  logic [SEQ_ENTRY_W-1:0] seq1;
  logic [SEQ_ENTRY_W-1:0] seq2;
  logic [SEQ_ENTRY_W-1:0] seq3;
  logic [COUNT_W-1:0]     precharge;   // clk cycles

  modport reg_mp (output seq_n, seq0, seq1, seq2, seq3, precharge);
  modport seq_mp (input seq_n, seq0, seq1, seq2, seq3, precharge);

endinterface

`default_nettype wire

/* hw/spi_cs_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cs_decode (
  input  logic             sck_i,
  input  logic             sdi_i,
  input  acq_pkg::spi_cs_e spi_cs_vec_i,
  output logic             glb_clk_o,
  output logic             glb_mosi_o,
  output logic             fpga_cs_n_o,
  output logic             strobe_4094_o,
  output logic             invert_dac_ss_o,
  output logic             iso_cs_o
);
  import acq_pkg::*;

  logic fpga_sel;

  assign fpga_sel = (spi_cs_vec_i == CS_FPGA0);

  // shared bus stays quiet while the register set is addressed
  assign glb_clk_o  = fpga_sel ? 1'b1 : sck_i;   // park hi
  assign glb_mosi_o = fpga_sel ? 1'b1 : sdi_i;   // park hi

  assign fpga_cs_n_o     = ~fpga_sel;                        // active lo
  assign strobe_4094_o   = (spi_cs_vec_i == CS_4094);        // active hi, park lo
  assign invert_dac_ss_o = (spi_cs_vec_i != CS_INVERT_DAC);  // active lo
  assign iso_cs_o        = (spi_cs_vec_i != CS_MDAC1);       // mdac, active lo

endmodule

`default_nettype wire

/* hw/spi_register_set.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_register_set (
  input  logic                          CLK,
  input  logic                          rst_i,
  input  logic                          sck_i,
  input  logic                          sdi_i,
  input  logic                          cs_n_i,
  input  logic [3:0]                    hw_flags_i,
  input  logic [acq_pkg::SEQ_IDX_W-1:0] sample_idx_last_i,
  input  logic                          first_last_i,
  output logic                          sdo_o,
  output acq_pkg::mode_e                cr_mode_o,
  output logic [acq_pkg::REG_W-1:0]     direct_o,
  output logic                          oe_4094_o,
  output logic [acq_pkg::COUNT_W-1:0]   aperture_o,
  seq_cfg_if.reg_mp                     cfg_o
);
  import acq_pkg::*;

  logic [2:0]           sck_q;        // [1] synced, [2] previous
  logic [2:0]           cs_q;
  logic [1:0]           sdi_q;
  logic                 sck_rise;
  logic                 sck_fall;
  logic                 cs_act;
  logic                 cs_fall;      // frame start
  logic                 cs_rise;      // frame end
  logic [BIT_CNT_W-1:0] bit_cnt;
  logic [FRAME_W-1:0]   rx_sr;
  logic [REG_W-1:0]     tx_sr;
  logic                 frame_end_q;
  logic                 wr_chk_q;
  logic                 wr_go_q;
  logic [ADDR_W-1:0]    wr_addr_q;
  logic [REG_W-1:0]     wr_data_q;
  logic [ADDR_W-1:0]    rd_addr;
  logic [REG_W-1:0]     rd_data;
  logic [REG_W-1:0]     status_w;
  logic [REG_W-1:0]     regs [REG_ADDR_CR:REG_ADDR_APERTURE];

  ////////////////////////////////////////////////////////////
  // synchronizers and edge detect

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      sck_q <= '0;
      cs_q  <= '1;   // deselected
    end else begin
      sck_q <= {sck_q[1:0], sck_i};
      cs_q  <= {cs_q[1:0], cs_n_i};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign cs_act   = ~cs_q[1];
  assign cs_fall  = ~cs_q[1] & cs_q[2];
  assign cs_rise  = cs_q[1] & ~cs_q[2];

  // magic, flags, last sample info
  assign status_w = {9'b0, cfg_o.seq_n, first_last_i, sample_idx_last_i,
                     4'b0, hw_flags_i, STATUS_MAGIC};

  // read mux, write bit ignored
  always_comb begin
    rd_addr = {1'b0, rx_sr[ADDR_W-2:0]};
    rd_data = '0;
    if (rd_addr == REG_ADDR_STATUS) begin
      rd_data = status_w;
    end else if (rd_addr >= REG_ADDR_CR && rd_addr <= REG_ADDR_APERTURE) begin
      rd_data = regs[rd_addr];
    end
  end

  ////////////////////////////////////////////////////////////
  // frame shift and commit pipeline

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      bit_cnt     <= '0;
      tx_sr       <= '0;
      frame_end_q <= 1'b0;
      wr_chk_q    <= 1'b0;
      wr_go_q     <= 1'b0;
    end else begin
      frame_end_q <= cs_rise;
      // full 40 bit frame with write bit set
      wr_chk_q    <= frame_end_q && (bit_cnt == BIT_CNT_W'(FRAME_W)) &&
                     rx_sr[REG_W + REG_WRITE_BIT];
      wr_go_q     <= wr_chk_q;
      if (cs_fall) begin
        bit_cnt <= '0;
        tx_sr   <= '0;
      end else if (cs_act) begin
        if (sck_rise && bit_cnt != '1) begin
          bit_cnt <= bit_cnt + 1'b1;   // saturates on long frames
        end
        if (sck_fall) begin
          if (bit_cnt == BIT_CNT_W'(ADDR_W)) begin
            tx_sr <= rd_data;          // address complete, status captured here
          end else begin
            tx_sr <= {tx_sr[REG_W-2:0], 1'b0};
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    sdi_q <= {sdi_q[0], sdi_i};
    if (cs_act && sck_rise) begin
      rx_sr <= {rx_sr[FRAME_W-2:0], sdi_q[1]};
    end
    if (wr_chk_q) begin
      wr_addr_q <= {1'b0, rx_sr[FRAME_W-2 -: ADDR_W-1]};
      wr_data_q <= rx_sr[REG_W-1:0];
    end
  end

  // register file, written in the last stage
  always_ff @(posedge CLK) begin
    if (rst_i) begin
      for (int i = REG_ADDR_CR; i <= REG_ADDR_APERTURE; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_go_q && wr_addr_q >= REG_ADDR_CR && wr_addr_q <= REG_ADDR_APERTURE) begin
      regs[wr_addr_q] <= wr_data_q;
    end
  end

  assign sdo_o = tx_sr[REG_W-1];   // msb first

  assign cr_mode_o       = mode_e'(regs[REG_ADDR_CR][2:0]);
  assign direct_o        = regs[REG_ADDR_DIRECT];
  assign oe_4094_o       = regs[REG_ADDR_4094_OE][0];   // lo at power up
  assign aperture_o      = regs[REG_ADDR_APERTURE][COUNT_W-1:0];
  assign cfg_o.precharge = regs[REG_ADDR_PRECHARGE][COUNT_W-1:0];
  assign cfg_o.seq_n     = regs[REG_ADDR_SEQ_N][SEQ_IDX_W-1:0];
  assign cfg_o.seq0      = regs[REG_ADDR_SEQ0][SEQ_ENTRY_W-1:0];
  assign cfg_o.seq1      = regs[REG_ADDR_SEQ1][SEQ_ENTRY_W-1:0];
  assign cfg_o.seq2      = regs[REG_ADDR_SEQ2][SEQ_ENTRY_W-1:0];
  assign cfg_o.seq3      = regs[REG_ADDR_SEQ3][SEQ_ENTRY_W-1:0];

endmodule

`default_nettype wire

/* hw/sequence_acquisition.sv */
`timescale 1ns/1ps
`default_nettype none

module sequence_acquisition (
  input  logic                          CLK,
  input  logic                          rst_i,
  input  logic                          trig_i,
  input  logic                          measure_valid_i,
  seq_cfg_if.seq_mp                     cfg_i,
  output logic [1:0]                    pc_sw_o,
  output logic [3:0]                    azmux_o,
  output logic                          adc_reset_n_o,
  output logic [3:0]                    leds_o,
  output logic [7:0]                    monitor_o,
  output logic [acq_pkg::SEQ_IDX_W-1:0] sample_idx_last_o,
  output logic                          first_last_o
);
  import acq_pkg::*;

  seq_state_e             state;
  logic                   trig_q;
  logic [COUNT_W-1:0]     pc_cnt;     // precharge timer
  logic [SEQ_IDX_W-1:0]   idx;
  logic [SEQ_IDX_W-1:0]   idx_max;
  logic [SEQ_IDX_W-1:0]   idx_next;
  logic [SEQ_ENTRY_W-1:0] entry;

  // pattern of the current sample, four slots
  always_comb begin
    case (idx[1:0])
      2'd0:    entry = cfg_i.seq0;
      2'd1:    entry = cfg_i.seq1;
      2'd2:    entry = cfg_i.seq2;
      default: entry = cfg_i.seq3;
    endcase
  end

  assign idx_max  = (cfg_i.seq_n == '0) ? '0 : cfg_i.seq_n - 1'b1;
  assign idx_next = (idx >= idx_max) ? '0 : idx + 1'b1;   // wrap at n

  ////////////////////////////////////////////////////////////
  // sample fsm

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      state             <= ST_IDLE;
      trig_q            <= 1'b0;
      pc_cnt            <= '0;
      idx               <= '0;
      sample_idx_last_o <= '0;
      first_last_o      <= 1'b0;
    end else begin
      trig_q <= trig_i;
      if (!trig_i) begin
        // trigger is a level, dropping it parks everything
        state  <= ST_IDLE;
        pc_cnt <= '0;
        idx    <= '0;
      end else begin
        case (state)
          ST_IDLE: begin
            if (!trig_q) begin
              state  <= ST_PRECHARGE;   // rising trigger
              pc_cnt <= '0;
            end
          end
          ST_PRECHARGE: begin
            if (pc_cnt == cfg_i.precharge) begin
              state <= ST_MEASURE;      // releases adc reset
            end else begin
              pc_cnt <= pc_cnt + 1'b1;
            end
          end
          ST_MEASURE: begin
            if (measure_valid_i) begin
              sample_idx_last_o <= idx;
              first_last_o      <= (idx == '0);
              idx               <= idx_next;
              pc_cnt            <= '0;
              state             <= ST_PRECHARGE;
            end
          end
          default: state <= ST_IDLE;
        endcase
      end
    end
  end

  assign adc_reset_n_o = (state == ST_MEASURE);
  assign azmux_o       = entry[3:0];
  assign pc_sw_o       = entry[5:4];

  assign leds_o    = {state, idx[1:0]};
  assign monitor_o = {adc_reset_n_o, measure_valid_i, state, 1'b0, idx};   // scope view

endmodule

`default_nettype wire

/* hw/adc_mock.sv */
`timescale 1ns/1ps
`default_nettype none

// stands in for the real adc, fixed aperture only
module adc_mock (
  input  logic                        CLK,
  input  logic                        rst_i,
  input  logic                        reset_n_i,
  input  logic [acq_pkg::COUNT_W-1:0] aperture_i,
  output logic                        measure_valid_o
);
  import acq_pkg::*;

  logic [COUNT_W-1:0] ap_cnt;
  logic [COUNT_W-1:0] ap_cnt_next;

  assign ap_cnt_next = ap_cnt + 1'b1;

  always_ff @(posedge CLK) begin
    if (rst_i || !reset_n_i) begin
      ap_cnt          <= '0;     // held while adc in reset
      measure_valid_o <= 1'b0;
    end else begin
      ap_cnt          <= ap_cnt_next;
      measure_valid_o <= (ap_cnt_next == aperture_i);   // single pulse per release
    end
  end

endmodule

`default_nettype wire

/* hw/mode_select.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_select (
  input  logic                      CLK,
  input  logic                      rst_i,
  input  acq_pkg::mode_e            mode_i,
  input  logic [acq_pkg::REG_W-1:0] direct_i,
  input  logic [1:0]                seq_pc_sw_i,
  input  logic [3:0]                seq_azmux_i,
  input  logic [3:0]                seq_leds_i,
  input  logic [7:0]                seq_monitor_i,
  output logic [3:0]                leds_o,
  output logic [7:0]                monitor_o,
  output logic [1:0]                pc_sw_o,
  output logic [3:0]                azmux_o,
  output logic [1:0]                adc_refmux_o,
  output logic                      adc_rstmux_o,
  output logic                      adc_sigmux_o,
  output logic                      adc_cmpr_latch_ctl_o,
  output logic                      spi_interrupt_ctl_o
);
  import acq_pkg::*;

  logic [OUT_W-1:0] out_nxt;
  logic [OUT_W-1:0] out_q;

  always_comb begin
    case (mode_i)
      MODE_DIRECT:   out_nxt = direct_i[OUT_W-1:0];   // register owns every pin
      MODE_SEQ_MOCK: out_nxt = {2'b00,                // spare
                                1'b0,                 // spi interrupt
                                1'b0,                 // cmpr latch
                                1'b0, 1'b0, 2'b00,    // adc sig, rst, ref mux
                                seq_azmux_i,          // 14
                                seq_pc_sw_i,          // 12
                                seq_monitor_i,        // 4
                                seq_leds_i};          // 0
      default:       out_nxt = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (rst_i) begin
      out_q <= '0;
    end else begin
      out_q <= out_nxt;
    end
  end

  // leds and monitor sit lowest, spare bits not pinned out
  assign {spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o, adc_sigmux_o, adc_rstmux_o,
          adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o} = out_q[OUT_W-3:0];

endmodule

`default_nettype wire

/* hw/acq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_top (
  input  logic       CLK,
  input  logic       rst_i,
  input  logic       sck_i,
  input  logic       sdi_i,
  input  logic [2:0] spi_cs_vec_i,
  input  logic [3:0] hw_flags_i,
  input  logic       sa_trig_i,
  output logic       sdo_o,
  output logic       spi_glb_clk_o,
  output logic       spi_glb_mosi_o,
  output logic       spi_4094_strobe_o,
  output logic       spi_4094_oe_o,
  output logic       spi_invert_dac_ss_o,
  output logic       spi_invert_dac_clk_o,
  output logic       spi_invert_dac_data_o,
  output logic       spi_iso_cs_o,
  output logic [3:0] leds_o,
  output logic [7:0] monitor_o,
  output logic [1:0] pc_sw_o,
  output logic [3:0] azmux_o,
  output logic [1:0] adc_refmux_o,
  output logic       adc_sigmux_o,
  output logic       adc_rstmux_o,
  output logic       adc_cmpr_latch_ctl_o,
  output logic       spi_interrupt_ctl_o
);
  import acq_pkg::*;

  logic                 glb_clk;
  logic                 glb_mosi;
  logic                 fpga_cs_n;
  mode_e                cr_mode;
  logic [REG_W-1:0]     direct;
  logic [COUNT_W-1:0]   aperture;
  logic [1:0]           seq_pc_sw;
  logic [3:0]           seq_azmux;
  logic [3:0]           seq_leds;
  logic [7:0]           seq_monitor;
  logic                 adc_reset_n;
  logic                 measure_valid;
  logic [SEQ_IDX_W-1:0] sample_idx_last;
  logic                 first_last;

  seq_cfg_if u_seq_cfg ();

  ////////////////////////////////////////////////////////////
  // spi routing

  spi_cs_decode u_spi_cs_decode (
    .sck_i           (sck_i),
    .sdi_i           (sdi_i),
    .spi_cs_vec_i    (spi_cs_e'(spi_cs_vec_i)),
    .glb_clk_o       (glb_clk),
    .glb_mosi_o      (glb_mosi),
    .fpga_cs_n_o     (fpga_cs_n),
    .strobe_4094_o   (spi_4094_strobe_o),
    .invert_dac_ss_o (spi_invert_dac_ss_o),
    .iso_cs_o        (spi_iso_cs_o)
  );

  // dac shares the global bus
  assign spi_glb_clk_o         = glb_clk;
  assign spi_glb_mosi_o        = glb_mosi;
  assign spi_invert_dac_clk_o  = glb_clk;
  assign spi_invert_dac_data_o = glb_mosi;

  spi_register_set u_spi_register_set (
    .CLK               (CLK),
    .rst_i             (rst_i),
    .sck_i             (sck_i),
    .sdi_i             (sdi_i),
    .cs_n_i            (fpga_cs_n),
    .hw_flags_i        (hw_flags_i),
    .sample_idx_last_i (sample_idx_last),
    .first_last_i      (first_last),
    .sdo_o             (sdo_o),
    .cr_mode_o         (cr_mode),
    .direct_o          (direct),
    .oe_4094_o         (spi_4094_oe_o),
    .aperture_o        (aperture),
    .cfg_o             (u_seq_cfg.reg_mp)
  );

  ////////////////////////////////////////////////////////////
  // acquisition and pin mux

  sequence_acquisition u_sequence_acquisition (
    .CLK               (CLK),
    .rst_i             (rst_i),
    .trig_i            (sa_trig_i),
    .measure_valid_i   (measure_valid),   // from the mock
    .cfg_i             (u_seq_cfg.seq_mp),
    .pc_sw_o           (seq_pc_sw),
    .azmux_o           (seq_azmux),
    .adc_reset_n_o     (adc_reset_n),
    .leds_o            (seq_leds),
    .monitor_o         (seq_monitor),
    .sample_idx_last_o (sample_idx_last),
    .first_last_o      (first_last)
  );

  adc_mock u_adc_mock (
    .CLK             (CLK),
    .rst_i           (rst_i),
    .reset_n_i       (adc_reset_n),
    .aperture_i      (aperture),
    .measure_valid_o (measure_valid)
  );

  mode_select u_mode_select (
    .CLK                  (CLK),
    .rst_i                (rst_i),
    .mode_i               (cr_mode),
    .direct_i             (direct),
    .seq_pc_sw_i          (seq_pc_sw),
    .seq_azmux_i          (seq_azmux),
    .seq_leds_i           (seq_leds),
    .seq_monitor_i        (seq_monitor),
    .leds_o               (leds_o),
    .monitor_o            (monitor_o),
    .pc_sw_o              (pc_sw_o),
    .azmux_o              (azmux_o),
    .adc_refmux_o         (adc_refmux_o),
    .adc_rstmux_o         (adc_rstmux_o),
    .adc_sigmux_o         (adc_sigmux_o),
    .adc_cmpr_latch_ctl_o (adc_cmpr_latch_ctl_o),
    .spi_interrupt_ctl_o  (spi_interrupt_ctl_o)
  );

endmodule

`default_nettype wire

/* verif/acq_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_assertions (
  input logic                                clk_i,
  input logic                                rst_i,
  input logic                                sck_i,
  input logic                                sdi_i,
  input logic [2:0]                          spi_cs_vec_i,
  input logic                                sa_trig_i,
  input logic                                glb_clk_i,
  input logic                                glb_mosi_i,
  input logic                                invert_dac_clk_i,
  input logic                                invert_dac_data_i,
  input logic                                fpga_cs_n_i,
  input logic                                strobe_4094_i,
  input logic                                invert_dac_ss_i,
  input logic                                iso_cs_i,
  input logic [acq_pkg::OUT_W-3:0]           pins_i,       // leds at bit 0
  input logic [2:0]                          mode_i,
  input logic [acq_pkg::REG_W-1:0]           direct_i,
  input logic [acq_pkg::COUNT_W-1:0]         precharge_i,
  input logic [acq_pkg::COUNT_W-1:0]         aperture_i,
  input logic [acq_pkg::SEQ_IDX_W-1:0]       seq_n_i,
  input logic [4*acq_pkg::SEQ_ENTRY_W-1:0]   seq_pat_i,    // seq3 .. seq0
  input acq_pkg::seq_state_e                 state_i,
  input logic [acq_pkg::SEQ_IDX_W-1:0]       idx_i,
  input logic                                adc_reset_n_i,
  input logic                                measure_valid_i
);
  import acq_pkg::*;

  int fail_cnt = 0;
  int gap;   // cycles since the last sample or trigger start

  // pattern slot for a sample index
  function automatic logic [SEQ_ENTRY_W-1:0] pattern_of(
    input logic [4*SEQ_ENTRY_W-1:0] pat,
    input logic [SEQ_IDX_W-1:0]     idx
  );
    return pat[idx[1:0]*SEQ_ENTRY_W +: SEQ_ENTRY_W];
  endfunction

  function automatic logic [SEQ_IDX_W-1:0] next_idx(
    input logic [SEQ_IDX_W-1:0] idx,
    input logic [SEQ_IDX_W-1:0] n
  );
    int len;
    len = (n == 0) ? 1 : int'(n);   // length 0 acts as 1
    return SEQ_IDX_W'((int'(idx) + 1) % len);
  endfunction

  always @(posedge clk_i) begin
    if (rst_i || !sa_trig_i) begin
      gap <= 0;
    end else if (measure_valid_i) begin
      gap <= 1;
    end else begin
      gap <= gap + 1;
    end
  end

  ////////////////////////////////////////////////////////////
  // combinational chip-select decode

  a_cs_selects: assert property (@(posedge clk_i)
    strobe_4094_i == (spi_cs_vec_i == CS_4094) &&
    fpga_cs_n_i == (spi_cs_vec_i != CS_FPGA0) &&
    invert_dac_ss_i == (spi_cs_vec_i != CS_INVERT_DAC) &&
    iso_cs_i == (spi_cs_vec_i != CS_MDAC1))
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: device selects wrong for cs %0d", $time, spi_cs_vec_i);
    end

  a_bus_park: assert property (@(posedge clk_i)
    glb_clk_i == ((spi_cs_vec_i == CS_FPGA0) ? 1'b1 : sck_i) &&
    glb_mosi_i == ((spi_cs_vec_i == CS_FPGA0) ? 1'b1 : sdi_i) &&
    invert_dac_clk_i == ((spi_cs_vec_i == CS_FPGA0) ? 1'b1 : sck_i) &&
    invert_dac_data_i == ((spi_cs_vec_i == CS_FPGA0) ? 1'b1 : sdi_i))
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: shared spi bus or dac lines not parked or passed", $time);
    end

  ////////////////////////////////////////////////////////////
  // pin bundle per mode

  a_direct: assert property (@(posedge clk_i) disable iff (rst_i)
    mode_i == MODE_DIRECT |=> pins_i == $past(direct_i[OUT_W-3:0]))
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: pins %h differ from direct word", $time, pins_i);
    end

  a_seq_pins: assert property (@(posedge clk_i) disable iff (rst_i)
    mode_i == MODE_SEQ_MOCK && sa_trig_i |=>
      pins_i[17:14] == $past(pattern_of(seq_pat_i, idx_i)) % 16 &&   // azmux
      pins_i[13:12] == $past(pattern_of(seq_pat_i, idx_i)) / 16 &&   // pc_sw
      pins_i[23:18] == '0)                                           // adc, latch, irq
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: sequence pins %h wrong for index %0d", $time, pins_i,
             $past(idx_i));
    end

  a_other_mode: assert property (@(posedge clk_i) disable iff (rst_i)
    mode_i != MODE_DIRECT && mode_i != MODE_SEQ_MOCK |=> pins_i == '0)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: mode %0d left pins %h driven", $time, $past(mode_i), pins_i);
    end

  ////////////////////////////////////////////////////////////
  // sequencer stepping

  a_idle: assert property (@(posedge clk_i) disable iff (rst_i)
    !sa_trig_i |=> state_i == ST_IDLE && idx_i == '0 && !adc_reset_n_i)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: sequencer not parked at index 0", $time);
    end

  a_advance: assert property (@(posedge clk_i) disable iff (rst_i)
    sa_trig_i && measure_valid_i && state_i == ST_MEASURE |=>
      idx_i == next_idx($past(idx_i), $past(seq_n_i)) &&
      state_i == ST_PRECHARGE && !adc_reset_n_i)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: index %0d after sample %0d", $time, idx_i, $past(idx_i));
    end

  a_period: assert property (@(posedge clk_i) disable iff (rst_i)
    sa_trig_i && measure_valid_i |-> gap == int'(precharge_i) + int'(aperture_i) + 2)
    else begin
      fail_cnt++;
      $error("Mismatch at %0t: sample took %0d cycles", $time, gap);
    end

endmodule

`default_nettype wire

/* verif/acq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module acq_tb;
  import acq_pkg::*;

  localparam int SCK_HALF    = 4;                          // clk cycles per sck phase
  localparam int FRAME_CYC   = FRAME_W * 2 * SCK_HALF + 20;
  localparam int N_FRAMES    = 30;
  localparam int PRECHARGE   = 5;
  localparam int APERTURE    = 7;
  localparam int SAMPLE_CYC  = PRECHARGE + APERTURE + 2;
  localparam int N_SAMPLES   = 13;                         // both sequence runs
  localparam int CYCLE_LIMIT = 2 * (N_FRAMES * FRAME_CYC + N_SAMPLES * SAMPLE_CYC) + 500;
  localparam int MON_VALID   = 6;                          // measure_valid in monitor byte

  logic       clk;
  logic       rst;
  logic       sck;
  logic       sdi;
  logic [2:0] cs_vec;
  logic [3:0] hw_flags;
  logic       sa_trig;
  logic       sdo;
  logic       glb_clk;
  logic       glb_mosi;
  logic       strobe_4094;
  logic       oe_4094;
  logic       dac_ss;
  logic       dac_clk;
  logic       dac_data;
  logic       iso_cs;
  logic [3:0] leds;
  logic [7:0] monitor;
  logic [1:0] pc_sw;
  logic [3:0] azmux;
  logic [1:0] adc_refmux;
  logic       adc_sigmux;
  logic       adc_rstmux;
  logic       cmpr_latch;
  logic       spi_irq;
  integer     seed;
  int         check_errors;
  int         timeout_errors;
  int         cycle_cnt;

  acq_top u_acq_top (
    .CLK (clk), .rst_i (rst), .sck_i (sck), .sdi_i (sdi),
    .spi_cs_vec_i (cs_vec), .hw_flags_i (hw_flags), .sa_trig_i (sa_trig),
    .sdo_o (sdo), .spi_glb_clk_o (glb_clk), .spi_glb_mosi_o (glb_mosi),
    .spi_4094_strobe_o (strobe_4094), .spi_4094_oe_o (oe_4094),
    .spi_invert_dac_ss_o (dac_ss), .spi_invert_dac_clk_o (dac_clk),
    .spi_invert_dac_data_o (dac_data), .spi_iso_cs_o (iso_cs),
    .leds_o (leds), .monitor_o (monitor), .pc_sw_o (pc_sw), .azmux_o (azmux),
    .adc_refmux_o (adc_refmux), .adc_sigmux_o (adc_sigmux), .adc_rstmux_o (adc_rstmux),
    .adc_cmpr_latch_ctl_o (cmpr_latch), .spi_interrupt_ctl_o (spi_irq)
  );

  bind acq_top acq_assertions u_acq_assertions (
    .clk_i (CLK), .rst_i (rst_i), .sck_i (sck_i), .sdi_i (sdi_i),
    .spi_cs_vec_i (spi_cs_vec_i), .sa_trig_i (sa_trig_i),
    .glb_clk_i (spi_glb_clk_o), .glb_mosi_i (spi_glb_mosi_o),
    .invert_dac_clk_i (spi_invert_dac_clk_o), .invert_dac_data_i (spi_invert_dac_data_o),
    .fpga_cs_n_i (fpga_cs_n),
    .strobe_4094_i (spi_4094_strobe_o), .invert_dac_ss_i (spi_invert_dac_ss_o),
    .iso_cs_i (spi_iso_cs_o),
    .pins_i ({spi_interrupt_ctl_o, adc_cmpr_latch_ctl_o, adc_sigmux_o, adc_rstmux_o,
              adc_refmux_o, azmux_o, pc_sw_o, monitor_o, leds_o}),
    .mode_i (cr_mode), .direct_i (direct), .precharge_i (u_seq_cfg.precharge),
    .aperture_i (aperture), .seq_n_i (u_seq_cfg.seq_n),
    .seq_pat_i ({u_seq_cfg.seq3, u_seq_cfg.seq2, u_seq_cfg.seq1, u_seq_cfg.seq0}),
    .state_i (u_sequence_acquisition.state), .idx_i (u_sequence_acquisition.idx),
    .adc_reset_n_i (adc_reset_n), .measure_valid_i (measure_valid)
  );

  always #20 clk = ~clk;   // 40 ns period

  ////////////////////////////////////////////////////////////
  // spi host in mode 0 with sck at 8 clk periods

  task automatic spi_frame(input logic [FRAME_W-1:0] tx, output logic [REG_W-1:0] rx);
    rx = '0;
    @(posedge clk);
    cs_vec <= CS_FPGA0;
    repeat (4) @(posedge clk);   // select through the synchronizer first
    for (int i = FRAME_W - 1; i >= 0; i--) begin
      sck <= 1'b0;
      sdi <= tx[i];
      repeat (SCK_HALF - 1) @(posedge clk);
      @(negedge clk);
      if (i < REG_W) begin
        rx = {rx[REG_W-2:0], sdo};   // data phase shifts in msb first
      end
      @(posedge clk);
      sck <= 1'b1;
      repeat (SCK_HALF) @(posedge clk);
    end
    sck <= 1'b0;
    repeat (4) @(posedge clk);
    cs_vec <= CS_DEASSERT;
    repeat (8) @(posedge clk);   // write commit lands in here
  endtask

  task automatic spi_write(input logic [ADDR_W-1:0] addr, input logic [REG_W-1:0] data);
    logic [REG_W-1:0] unused;
    spi_frame({1'b1, addr[ADDR_W-2:0], data}, unused);
  endtask

  task automatic spi_read(input logic [ADDR_W-1:0] addr, output logic [REG_W-1:0] data);
    spi_frame({1'b0, addr[ADDR_W-2:0], {REG_W{1'b0}}}, data);
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      check_errors++;
      $error("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic write_and_verify(input string what, input logic [ADDR_W-1:0] addr,
                                  input logic [REG_W-1:0] data);
    logic [REG_W-1:0] rd;
    spi_write(addr, data);
    spi_read(addr, rd);
    check_value(what, rd, data);
  endtask

  // every cs code with the bus toggling
  task automatic sweep_chip_selects();
    logic [31:0] rnd;
    for (int cs = 0; cs <= 4; cs++) begin
      @(posedge clk);
      cs_vec <= cs[2:0];
      repeat (6) begin
        @(posedge clk);
        rnd = $random(seed);
        sck <= rnd[0];
        sdi <= rnd[1];
      end
    end
    @(posedge clk);
    cs_vec <= CS_DEASSERT;
    sck    <= 1'b0;
    sdi    <= 1'b0;
    repeat (8) @(posedge clk);
  endtask

  // count samples on the monitor then check status
  task automatic run_sequence(input int n, input int samples);
    int               seen;
    int               last;
    logic [REG_W-1:0] status;
    seen = 0;
    write_and_verify("seq_n", REG_ADDR_SEQ_N, n);
    @(posedge clk);
    sa_trig <= 1'b1;
    while (seen < samples) begin
      @(negedge clk);
      if (monitor[MON_VALID]) begin
        seen++;
      end
    end
    @(posedge clk);
    sa_trig <= 1'b0;
    repeat (20) @(posedge clk);   // rest at index 0
    spi_read(REG_ADDR_STATUS, status);
    last = (samples - 1) % n;
    check_value("status last index", status[18:16], last);
    check_value("status first_last", status[19], last == 0);
    check_value("status seq_n", status[22:20], n);
  endtask

  task automatic report_and_finish();
    int assert_errors;
    assert_errors = u_acq_top.u_acq_assertions.fail_cnt;
    $display("summary: %0d assertion failures, %0d check failures, %0d timeouts",
             assert_errors, check_errors, timeout_errors);
    if (assert_errors + check_errors + timeout_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
      timeout_errors = 1;
      report_and_finish();
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus

  initial begin
    logic [31:0] rnd;
    logic [31:0] status;
    clk            = 1'b0;
    rst            = 1'b1;
    sck            = 1'b0;
    sdi            = 1'b0;
    cs_vec         = CS_DEASSERT;
    hw_flags       = 4'h0;
    sa_trig        = 1'b0;
    seed           = 23;
    check_errors   = 0;
    timeout_errors = 0;
    cycle_cnt      = 0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    repeat (4) @(posedge clk);
    check_value("4094 oe after reset", oe_4094, 1'b0);

    sweep_chip_selects();

    // pins follow the direct word in direct mode
    rnd = $random(seed);
    write_and_verify("direct word", REG_ADDR_DIRECT, rnd);
    spi_write(REG_ADDR_4094_OE, 32'h1);
    check_value("4094 oe set", oe_4094, 1'b1);
    spi_write(REG_ADDR_4094_OE, 32'h0);
    check_value("4094 oe clear", oe_4094, 1'b0);

    // status with fresh flags
    rnd = $random(seed);
    @(posedge clk);
    hw_flags <= rnd[3:0];
    spi_read(REG_ADDR_STATUS, status);
    check_value("status magic", status[7:0], STATUS_MAGIC);
    check_value("status hw flags", status[11:8], rnd[3:0]);

    // sequencer setup with random patterns
    write_and_verify("precharge", REG_ADDR_PRECHARGE, PRECHARGE);
    write_and_verify("aperture", REG_ADDR_APERTURE, APERTURE);
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      write_and_verify("pattern", ADDR_W'(REG_ADDR_SEQ0 + i), rnd[SEQ_ENTRY_W-1:0]);
    end
    write_and_verify("mode", REG_ADDR_CR, MODE_SEQ_MOCK);
    run_sequence(3, 7);   // ends on index 0
    run_sequence(4, 6);   // ends on index 1

    // unsupported mode with the trigger up
    spi_write(REG_ADDR_CR, 32'h3);
    @(posedge clk);
    sa_trig <= 1'b1;
    repeat (40) @(posedge clk);
    sa_trig <= 1'b0;
    repeat (10) @(posedge clk);
    report_and_finish();
  end

endmodule

`default_nettype wire

/* list.f */
hw/acq_pkg.sv
hw/seq_cfg_if.sv
hw/spi_cs_decode.sv
hw/spi_register_set.sv
hw/sequence_acquisition.sv
hw/adc_mock.sv
hw/mode_select.sv
hw/acq_top.sv
verif/acq_assertions.sv
verif/acq_tb.sv
